// ==== verilog/tcdm_pkg.sv ====
// tcdm shared types
package tcdm_pkg;

  // bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;  // one enable per byte
  localparam int unsigned IdxWidth  = 2;

  // byte address
  typedef logic [AddrWidth-1:0] addr_t;

  // data word
  typedef logic [DataWidth-1:0] data_t;

  // byte enables
  typedef logic [BeWidth-1:0] be_t;

  // decoded bank index
  typedef logic [IdxWidth-1:0] port_idx_t;

  // index values, zero means unmapped
  localparam port_idx_t IDX_NONE  = port_idx_t'(2'd0);
  localparam port_idx_t IDX_BANK0 = port_idx_t'(2'd1);
  localparam port_idx_t IDX_BANK1 = port_idx_t'(2'd2);

endpackage

// ==== verilog/tcdm_addr_decode.sv ====
// TCDM address decoder
`timescale 1ns/1ps

module tcdm_addr_decode (
  input  tcdm_pkg::addr_t     addr_i,
  input  tcdm_pkg::addr_t     map0_start_i,
  input  tcdm_pkg::addr_t     map0_end_i,
  input  tcdm_pkg::addr_t     map1_start_i,
  input  tcdm_pkg::addr_t     map1_end_i,
  output tcdm_pkg::port_idx_t idx_o
);

  logic hit0;
  logic hit1;

  // half-open ranges, end address excluded
  assign hit0 = (addr_i >= map0_start_i) && (addr_i < map0_end_i);
  assign hit1 = (addr_i >= map1_start_i) && (addr_i < map1_end_i);

  // rule 1 wins on overlap
  always_comb begin
    if (hit1) begin
      idx_o = tcdm_pkg::IDX_BANK1;
    end else if (hit0) begin
      idx_o = tcdm_pkg::IDX_BANK0;
    end else begin
      idx_o = tcdm_pkg::IDX_NONE;  // unmapped, never granted
    end
  end

endmodule

// ==== verilog/tcdm_id_fifo.sv ====
// response ID FIFO
`timescale 1ns/1ps

module tcdm_id_fifo #(
  parameter int unsigned Depth = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                push_i,
  input  tcdm_pkg::port_idx_t idx_i,
  input  logic                pop_i,
  output tcdm_pkg::port_idx_t idx_o,
  output logic                full_o,
  output logic                empty_o
);

  localparam int unsigned PtrBits = (Depth > 1) ? $clog2(Depth) : 1;

  typedef logic [PtrBits-1:0] ptr_t;
  typedef logic [PtrBits:0]   count_t;

  tcdm_pkg::port_idx_t buf_q [Depth];
  ptr_t                wr_ptr_q;
  ptr_t                rd_ptr_q;
  count_t              count_q;
  logic                push_en;
  logic                pop_en;

  // wrap at Depth, which need not be a power of two
  function automatic ptr_t next_ptr(input ptr_t ptr);
    next_ptr = (ptr == ptr_t'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == count_t'(Depth));
  assign empty_o = (count_q == '0);

  assign pop_en  = pop_i & ~empty_o;
  assign push_en = push_i & (~full_o | pop_en);  // push on full only with a pop

  // idle head reads as unmapped
  assign idx_o = empty_o ? tcdm_pkg::IDX_NONE : buf_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_en) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // none, or both at once
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_en) buf_q[wr_ptr_q] <= idx_i;
  end

endmodule

// ==== verilog/tcdm_demux.sv ====
// TCDM demux, one requester to two banks
`timescale 1ns/1ps

module tcdm_demux #(
  parameter int unsigned IdFifoDepth   = 4,
  parameter bit          Bank1ReadOnly = 1'b1
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  // requester side
  input  logic            req_i,
  input  logic            we_i,
  input  tcdm_pkg::be_t   be_i,
  input  tcdm_pkg::addr_t addr_i,
  input  tcdm_pkg::data_t wdata_i,
  output logic            gnt_o,
  output logic            rvalid_o,
  output tcdm_pkg::data_t rdata_o,
  // address map
  input  tcdm_pkg::addr_t map0_start_i,
  input  tcdm_pkg::addr_t map0_end_i,
  input  tcdm_pkg::addr_t map1_start_i,
  input  tcdm_pkg::addr_t map1_end_i,
  // bank 0
  output logic            bank0_req_o,
  output logic            bank0_we_o,
  output tcdm_pkg::be_t   bank0_be_o,
  output tcdm_pkg::addr_t bank0_addr_o,
  output tcdm_pkg::data_t bank0_wdata_o,
  input  logic            bank0_gnt_i,
  input  logic            bank0_rvalid_i,
  input  tcdm_pkg::data_t bank0_rdata_i,
  // bank 1
  output logic            bank1_req_o,
  output logic            bank1_we_o,
  output tcdm_pkg::be_t   bank1_be_o,
  output tcdm_pkg::addr_t bank1_addr_o,
  output tcdm_pkg::data_t bank1_wdata_o,
  input  logic            bank1_gnt_i,
  input  logic            bank1_rvalid_i,
  input  tcdm_pkg::data_t bank1_rdata_i
);

  tcdm_pkg::port_idx_t sel_idx;  // decoded from addr_i
  tcdm_pkg::port_idx_t rsp_idx;  // bank of the oldest outstanding request
  logic                fifo_full;
  logic                fifo_empty;
  logic                fifo_push;
  logic                fifo_pop;
  logic                req_ok;

  tcdm_addr_decode u_addr_decode (
    .addr_i       (addr_i),
    .map0_start_i (map0_start_i),
    .map0_end_i   (map0_end_i),
    .map1_start_i (map1_start_i),
    .map1_end_i   (map1_end_i),
    .idx_o        (sel_idx)
  );

  tcdm_id_fifo #(
    .Depth (IdFifoDepth)
  ) u_id_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (fifo_push),
    .idx_i   (sel_idx),
    .pop_i   (fifo_pop),
    .idx_o   (rsp_idx),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  // a bank only sees a request that can be tracked
  assign req_ok = req_i & ~fifo_full;

  assign bank0_req_o   = req_ok & (sel_idx == tcdm_pkg::IDX_BANK0);
  assign bank0_we_o    = we_i;
  assign bank0_be_o    = be_i;
  assign bank0_addr_o  = addr_i;
  assign bank0_wdata_o = wdata_i;

  // read-only bank 1: writes become full-word reads
  assign bank1_req_o   = req_ok & (sel_idx == tcdm_pkg::IDX_BANK1);
  assign bank1_we_o    = Bank1ReadOnly ? 1'b0 : we_i;
  assign bank1_be_o    = Bank1ReadOnly ? '1 : be_i;
  assign bank1_addr_o  = addr_i;
  assign bank1_wdata_o = wdata_i;

  always_comb begin
    gnt_o = 1'b0;
    if (req_ok) begin
      case (sel_idx)
        tcdm_pkg::IDX_BANK0: gnt_o = bank0_gnt_i;
        tcdm_pkg::IDX_BANK1: gnt_o = bank1_gnt_i;
        default:             gnt_o = 1'b0;  // unmapped
      endcase
    end
  end

  assign fifo_push = gnt_o;
  assign fifo_pop  = rvalid_o & ~fifo_empty;

  assign rvalid_o = bank0_rvalid_i | bank1_rvalid_i;

  // responses come back in request order
  always_comb begin
    case (rsp_idx)
      tcdm_pkg::IDX_BANK0: rdata_o = bank0_rdata_i;
      tcdm_pkg::IDX_BANK1: rdata_o = bank1_rdata_i;
      default:             rdata_o = '0;
    endcase
  end

endmodule

// ==== verilog/tcdm_sram_bank.sv ====
// single-port SRAM bank
`timescale 1ns/1ps

module tcdm_sram_bank #(
  parameter int unsigned Words = 256
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  logic            we_i,
  input  tcdm_pkg::be_t   be_i,
  input  tcdm_pkg::addr_t addr_i,
  input  tcdm_pkg::data_t wdata_i,
  output logic            gnt_o,
  output logic            rvalid_o,
  output tcdm_pkg::data_t rdata_o
);

  localparam int unsigned IdxBits = (Words > 1) ? $clog2(Words) : 1;

  typedef logic [IdxBits-1:0] word_idx_t;

  tcdm_pkg::data_t mem_q [Words];
  word_idx_t       word_idx;

  assign gnt_o    = req_i;  // never stalls
  assign word_idx = addr_i[IdxBits+1:2];  // drop byte offset

  // contents, cleared on reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < Words; w++) begin
        mem_q[w] <= '0;
      end
    end else if (req_i && we_i) begin
      for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
        if (be_i[b]) mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  // response strobe, for reads and writes alike
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

  // old word, before this access
  always_ff @(posedge clk_i) begin
    if (req_i) rdata_o <= mem_q[word_idx];
  end

endmodule

// ==== verilog/tcdm_mem_subsys.sv ====
// TCDM memory subsystem top
`timescale 1ns/1ps

module tcdm_mem_subsys #(
  parameter int unsigned BankWords     = 256,
  parameter int unsigned IdFifoDepth   = 4,
  parameter bit          Bank1ReadOnly = 1'b1
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  logic            we_i,
  input  tcdm_pkg::be_t   be_i,
  input  tcdm_pkg::addr_t addr_i,
  input  tcdm_pkg::data_t wdata_i,
  output logic            gnt_o,
  output logic            rvalid_o,
  output tcdm_pkg::data_t rdata_o,
  input  tcdm_pkg::addr_t map0_start_i,
  input  tcdm_pkg::addr_t map0_end_i,
  input  tcdm_pkg::addr_t map1_start_i,
  input  tcdm_pkg::addr_t map1_end_i
);

  // bank 0 wires
  logic            bank0_req, bank0_we, bank0_gnt, bank0_rvalid;
  tcdm_pkg::be_t   bank0_be;
  tcdm_pkg::addr_t bank0_addr;
  tcdm_pkg::data_t bank0_wdata, bank0_rdata;

  // bank 1 wires
  logic            bank1_req, bank1_we, bank1_gnt, bank1_rvalid;
  tcdm_pkg::be_t   bank1_be;
  tcdm_pkg::addr_t bank1_addr;
  tcdm_pkg::data_t bank1_wdata, bank1_rdata;

  tcdm_demux #(
    .IdFifoDepth   (IdFifoDepth),
    .Bank1ReadOnly (Bank1ReadOnly)
  ) u_demux (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .we_i           (we_i),
    .be_i           (be_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .gnt_o          (gnt_o),
    .rvalid_o       (rvalid_o),
    .rdata_o        (rdata_o),
    .map0_start_i   (map0_start_i),
    .map0_end_i     (map0_end_i),
    .map1_start_i   (map1_start_i),
    .map1_end_i     (map1_end_i),
    .bank0_req_o    (bank0_req),
    .bank0_we_o     (bank0_we),
    .bank0_be_o     (bank0_be),
    .bank0_addr_o   (bank0_addr),
    .bank0_wdata_o  (bank0_wdata),
    .bank0_gnt_i    (bank0_gnt),
    .bank0_rvalid_i (bank0_rvalid),
    .bank0_rdata_i  (bank0_rdata),
    .bank1_req_o    (bank1_req),
    .bank1_we_o     (bank1_we),
    .bank1_be_o     (bank1_be),
    .bank1_addr_o   (bank1_addr),
    .bank1_wdata_o  (bank1_wdata),
    .bank1_gnt_i    (bank1_gnt),
    .bank1_rvalid_i (bank1_rvalid),
    .bank1_rdata_i  (bank1_rdata)
  );

  tcdm_sram_bank #(
    .Words (BankWords)
  ) u_bank0 (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (bank0_req),
    .we_i     (bank0_we),
    .be_i     (bank0_be),
    .addr_i   (bank0_addr),
    .wdata_i  (bank0_wdata),
    .gnt_o    (bank0_gnt),
    .rvalid_o (bank0_rvalid),
    .rdata_o  (bank0_rdata)
  );

  tcdm_sram_bank #(
    .Words (BankWords)
  ) u_bank1 (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (bank1_req),
    .we_i     (bank1_we),
    .be_i     (bank1_be),
    .addr_i   (bank1_addr),
    .wdata_i  (bank1_wdata),
    .gnt_o    (bank1_gnt),
    .rvalid_o (bank1_rvalid),
    .rdata_o  (bank1_rdata)
  );

endmodule

// ==== verification/tcdm_demux_sva.sv ====
// demux protocol assertions
`timescale 1ns/1ps

module tcdm_demux_sva (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            gnt_i,
  input logic            rvalid_i,
  input tcdm_pkg::addr_t addr_i,
  input tcdm_pkg::addr_t map0_start_i,
  input tcdm_pkg::addr_t map0_end_i,
  input tcdm_pkg::addr_t map1_start_i,
  input tcdm_pkg::addr_t map1_end_i,
  input logic            bank0_req_i,
  input logic            bank1_req_i
);

  int unsigned err_count = 0;  // read by the testbench top
  logic        in_map0;
  logic        in_map1;

  // rule match straight from the map with the end address excluded
  assign in_map0 = (addr_i >= map0_start_i) && (addr_i < map0_end_i);
  assign in_map1 = (addr_i >= map1_start_i) && (addr_i < map1_end_i);

  // response exactly one cycle after a grant
  a_rsp_after_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_i |=> rvalid_i)
    else begin
      err_count++;
      $error("rvalid missing one cycle after grant");
    end

  a_no_rsp_without_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> $past(gnt_i))
    else begin
      err_count++;
      $error("rvalid without a grant in the previous cycle");
    end

  // unmapped address reaches no bank
  a_no_req_unmapped : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(in_map0 || in_map1) |-> !(bank0_req_i || bank1_req_i))
    else begin
      err_count++;
      $error("bank request raised for an unmapped address");
    end

  // requests only reach the bank the map selects, so never both
  a_one_bank_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!bank0_req_i || (in_map0 && !in_map1)) && (!bank1_req_i || in_map1))
    else begin
      err_count++;
      $error("bank request does not match the address map");
    end

endmodule

// ==== verification/tcdm_checker.sv ====
// TCDM response checker
`timescale 1ns/1ps

module tcdm_checker (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            rvalid_i,
  input tcdm_pkg::data_t rdata_i
);

  string           name_q [$];  // test names in grant order
  tcdm_pkg::data_t data_q [$];
  int unsigned     n_pass = 0;
  int unsigned     n_fail = 0;

  // called once per granted request
  function automatic void expect_rsp(input string name, input tcdm_pkg::data_t data);
    name_q.push_back(name);
    data_q.push_back(data);
  endfunction

  function automatic int unsigned pending();
    return data_q.size();
  endfunction

  // outcome of a test with no response to compare
  function automatic void note_result(input string name, input bit ok, input string what);
    if (ok) begin
      n_pass++;
      $display("ok     %s: %s", name, what);
    end else begin
      n_fail++;
      $display("%s failed: %s", name, what);
    end
  endfunction

  // outputs are registered, so they are stable at the falling edge
  always @(negedge clk_i) begin
    string           name;
    tcdm_pkg::data_t exp_data;
    if (rst_ni && rvalid_i) begin
      if (data_q.size() == 0) begin
        n_fail++;
        $display("response 0x%08h arrived with no request outstanding", rdata_i);
      end else begin
        name     = name_q.pop_front();
        exp_data = data_q.pop_front();
        if (rdata_i === exp_data) begin
          n_pass++;
          $display("ok     %s: 0x%08h", name, rdata_i);
        end else begin
          n_fail++;
          $display("Error %s: expected 0x%08h, actual 0x%08h", name, exp_data, rdata_i);
        end
      end
    end
  end

endmodule

// ==== verification/tcdm_mem_subsys_tb.sv ====
// TCDM subsystem testbench
`timescale 1ns/1ps

module tcdm_mem_subsys_tb;

  localparam int unsigned GntTimeout = 20;  // cycles
  localparam int unsigned RspTimeout = 20;
  localparam int unsigned UnmapWait  = 8;   // cycles without grant before drop

  logic            clk;
  logic            rst_n;
  logic            req;
  logic            we;
  tcdm_pkg::be_t   be;
  tcdm_pkg::addr_t addr;
  tcdm_pkg::data_t wdata;
  logic            gnt;
  logic            rvalid;
  tcdm_pkg::data_t rdata;
  tcdm_pkg::addr_t map0_start;
  tcdm_pkg::addr_t map0_end;
  tcdm_pkg::addr_t map1_start;
  tcdm_pkg::addr_t map1_end;

  tcdm_mem_subsys #(
    .BankWords     (256),
    .IdFifoDepth   (4),
    .Bank1ReadOnly (1'b1)
  ) u_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_i        (req),
    .we_i         (we),
    .be_i         (be),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .gnt_o        (gnt),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .map0_start_i (map0_start),
    .map0_end_i   (map0_end),
    .map1_start_i (map1_start),
    .map1_end_i   (map1_end)
  );

  tcdm_checker u_checker (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .rvalid_i (rvalid),
    .rdata_i  (rdata)
  );

  bind tcdm_demux tcdm_demux_sva u_demux_sva (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .gnt_i        (gnt_o),
    .rvalid_i     (rvalid_o),
    .addr_i       (addr_i),
    .map0_start_i (map0_start_i),
    .map0_end_i   (map0_end_i),
    .map1_start_i (map1_start_i),
    .map1_end_i   (map1_end_i),
    .bank0_req_i  (bank0_req_o),
    .bank1_req_i  (bank1_req_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // driven on the falling edge and gnt read once inputs settle
  task automatic issue(input bit wr, input tcdm_pkg::addr_t a, input tcdm_pkg::be_t b,
                       input tcdm_pkg::data_t d, input int unsigned limit,
                       output bit granted);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    req   = 1'b1;
    we    = wr;
    be    = b;
    addr  = a;
    wdata = d;
    #1;
    while (!gnt && waited < limit) begin
      @(negedge clk);
      #1;
      waited++;
    end
    granted = gnt;
  endtask

  task automatic idle(input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk);
      req = 1'b0;
    end
  endtask

  initial begin
    int              fd;
    string           line;
    string           name;
    string           op;
    tcdm_pkg::addr_t a;
    tcdm_pkg::be_t   b;
    tcdm_pkg::data_t d;
    tcdm_pkg::data_t exp_data;
    int              chain;
    bit              granted;
    int unsigned     waited;
    int unsigned     sva_errs;
    rst_n      = 1'b0;
    req        = 1'b0;
    we         = 1'b0;
    be         = '0;
    addr       = '0;
    wdata      = '0;
    map0_start = 32'h0000_0000;
    map0_end   = 32'h0000_0400;
    map1_start = 32'h0000_1000;
    map1_end   = 32'h0000_1400;
    void'($urandom(32'ha150_9340));
    fd = $fopen("verification/tcdm_stim.txt", "r");
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    while (fd != 0 && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      if ($sscanf(line, "%s %s %h %h %h %h %d", name, op, a, b, d, exp_data, chain) != 7)
        continue;
      if (chain == 0) idle($urandom % 3);  // random idle gap
      if (op == "U") begin
        issue(1'b0, a, b, d, UnmapWait, granted);
        idle(1);  // requester gives up
        if (granted) u_checker.note_result(name, 1'b0, "unmapped address was granted");
        else u_checker.note_result(name, 1'b1, "no grant for unmapped address, dropped");
      end else begin
        issue(op == "W", a, b, d, GntTimeout, granted);
        if (granted) u_checker.expect_rsp(name, exp_data);
        else u_checker.note_result(name, 1'b0, "no grant within the timeout");
      end
    end
    if (fd == 0) u_checker.note_result("stim", 1'b0, "stimulus file could not be opened");
    else $fclose(fd);
    idle(1);
    waited = 0;
    while (u_checker.pending() != 0 && waited < RspTimeout) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (u_checker.pending() != 0) begin
      u_checker.note_result("drain", 1'b0, "responses never arrived");
    end
    sva_errs = u_dut.u_demux.u_demux_sva.err_count;
    $display("tests: %0d passed, %0d failed, %0d assertion errors",
             u_checker.n_pass, u_checker.n_fail, sva_errs);
    if (u_checker.n_fail == 0 && sva_errs == 0 && u_checker.n_pass != 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // overall limit on the run
  initial begin
    repeat (4000) @(posedge clk);
    $display("simulation did not finish within 4000 cycles");
    $display("Test failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/tcdm_pkg.sv
verilog/tcdm_addr_decode.sv
verilog/tcdm_id_fifo.sv
verilog/tcdm_demux.sv
verilog/tcdm_sram_bank.sv
verilog/tcdm_mem_subsys.sv
verification/tcdm_demux_sva.sv
verification/tcdm_checker.sv
verification/tcdm_mem_subsys_tb.sv

// ==== verification/tcdm_stim.txt ====
# columns: test name, op (W write, R read, U unmapped), address, byte enable,
# write data, expected response data (old word for writes), chain (1 = no idle before)
rst_b0_rd    R 00000040 f 00000000 00000000 0
b0_wr        W 00000010 f 11223344 00000000 0
b0_rd        R 00000010 f 00000000 11223344 0
b0_part_wr   W 00000010 3 0000aabb 11223344 0
b0_part_rd   R 00000010 f 00000000 1122aabb 0
b1_ro_wr     W 00001020 f deadbeef 00000000 0
b1_ro_rd     R 00001020 f 00000000 00000000 0
dec_b0_wr    W 00000020 f 5a5a5a5a 00000000 0
dec_b1_rd    R 00001020 f 00000000 00000000 0
dec_b0_rd    R 00000020 f 00000000 5a5a5a5a 0
dec_end0     U 00000400 f 00000000 00000000 0
dec_end1     U 00001400 f 00000000 00000000 0
unmapped     U 00002000 f 00000000 00000000 0
after_unmap  R 00000010 f 00000000 1122aabb 0
b2b_b0_wr    W 00000030 f 01020304 00000000 0
b2b_b1_rd    R 00001030 f 00000000 00000000 1
b2b_b0_rd    R 00000030 f 00000000 01020304 1
b2b_b1_wr    W 00001030 f ffffffff 00000000 1
b2b_b0_rd2   R 00000010 f 00000000 1122aabb 1
